//--- common/instr_defs.sv
// Opcodes, compressed-instruction codes and memory sizes for the fetch front end.
// Imported by every RTL module and by the testbench.

package instr_defs;

  // Width of the fetch read window.
  localparam int MemBusWidth = 32;

  // Canonical addi x0,x0,0, issued as the bubble after any redirect.
  localparam logic [31:0] Nop = 32'h0000_0013;

  // Major opcodes of full-size instructions.
  localparam logic [6:0] OpJal    = 7'b110_1111;  // Direct jump and link.
  localparam logic [6:0] OpBranch = 7'b110_0011;  // B-type conditional branch.

  // Low two bits that mark a full-size instruction.
  localparam logic [1:0] QuadFull = 2'b11;

  // Compressed quadrant C1 and the funct3 codes used by fetch.
  localparam logic [1:0] QuadC1 = 2'b01;
  localparam logic [2:0] C1Jal  = 3'b001;  // c.jal, RV32 only.
  localparam logic [2:0] C1J    = 3'b101;  // c.j.
  localparam logic [2:0] C1Beqz = 3'b110;  // c.beqz.
  localparam logic [2:0] C1Bnez = 3'b111;  // c.bnez.

  // Instruction memory depth, 1 KiB in halfwords.
  localparam int ImemHalfwords = 512;
  localparam int ImemAddrBits  = $clog2(ImemHalfwords);

  // Each bank holds every other halfword.
  localparam int ImemBankDepth = ImemHalfwords / 2;
  localparam int ImemBankBits  = ImemAddrBits - 1;

  // Size of the APB byte window covered by the memory.
  localparam int ImemBytes = ImemHalfwords * 2;

  // Sequential PC steps in halfwords.
  localparam logic [31:1] PcStepC    = 31'd1;
  localparam logic [31:1] PcStepFull = 31'd2;

endpackage : instr_defs

//--- fetch/riscv_decoder_br.sv
// Flags conditional branches in the fetched halfword, both B-type and c.beqz/c.bnez.
// The lower halfword is enough to tell both forms apart.

`timescale 1ns/100ps

module riscv_decoder_br
  import instr_defs::*;
(
  input  logic [15:0] instr,
  output logic        br
);

  logic       is_full;
  logic       is_c1;
  logic [2:0] c_funct3;
  logic       br_full;
  logic       br_comp;

  assign is_full  = (instr[1:0] == QuadFull);
  assign is_c1    = (instr[1:0] == QuadC1);
  assign c_funct3 = instr[15:13];

  // Full-size B-type, opcode checked above the size bits.
  assign br_full = is_full && (instr[6:2] == OpBranch[6:2]);

  // Compressed compare-with-zero branches.
  assign br_comp = is_c1 && ((c_funct3 == C1Beqz) || (c_funct3 == C1Bnez));

  assign br = br_full || br_comp;

endmodule : riscv_decoder_br

//--- fetch/riscv_decoder_j_no_rr.sv
// Flags direct jumps that fetch can resolve on its own: jal, c.j and c.jal.
// jalr and c.jr need a register value and are left to later stages.

`timescale 1ns/100ps

module riscv_decoder_j_no_rr
  import instr_defs::*;
(
  input  logic [15:0] instr,
  output logic        j
);

  logic       j_full;
  logic       j_comp;
  logic [2:0] c_funct3;

  assign c_funct3 = instr[15:13];

  assign j_full = (instr[6:0] == OpJal);  // Size bits are part of the opcode.

  assign j_comp = (instr[1:0] == QuadC1) &&
                  ((c_funct3 == C1J) || (c_funct3 == C1Jal));

  assign j = j_full || j_comp;

endmodule : riscv_decoder_j_no_rr

//--- fetch/riscv_decoder_j_no_rr_imm.sv
// Extracts the sign-extended byte offset of a direct jump.
// Handles the J-type layout of jal and the CJ layout of c.j/c.jal; valid only while j is set.

`timescale 1ns/100ps

module riscv_decoder_j_no_rr_imm
  import instr_defs::*;
(
  input  logic [31:0] instr,
  output logic [31:0] imm
);

  logic        is_full;
  logic [31:0] imm_j;
  logic [31:0] imm_cj;

  assign is_full = (instr[1:0] == QuadFull);

  // J-type holds imm[20|10:1|11|19:12] in bits 31:12.
  assign imm_j = {
    {12{instr[31]}},
    instr[19:12],
    instr[20],
    instr[30:21],
    1'b0
  };

  // CJ format holds offset[11|4|9:8|10|6|7|3:1|5] in bits 12:2.
  assign imm_cj = {
    {20{instr[12]}},
    instr[12],    // offset[11]
    instr[8],     // offset[10]
    instr[10:9],  // offset[9:8]
    instr[6],     // offset[7]
    instr[7],     // offset[6]
    instr[2],     // offset[5]
    instr[11],    // offset[4]
    instr[5:3],   // offset[3:1]
    1'b0
  };

  assign imm = is_full ? imm_j : imm_cj;

endmodule : riscv_decoder_j_no_rr_imm

//--- fetch/if_stage.sv
// Fetch stage: holds the PC, picks redirect, jump target or sequential step,
// and registers the fetched instruction into the d0 outputs.

`timescale 1ns/100ps

module if_stage
  import instr_defs::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_hold,
  input  logic                   pc_update,
  input  logic [           31:1] pc_in,
  input  logic [MemBusWidth-1:0] fetch_data,
  output logic [           31:1] fetch_addr,
  output logic [           31:1] pc_out,
  output logic [           31:0] instr_d0,
  output logic [           31:1] pc_d0,
  output logic                   compressed_d0,
  output logic                   br_d0,
  output logic                   valid_d0
);

  logic [31:1] pc;
  logic        compressed;
  logic        j;
  logic [31:0] jimm;
  logic        br;
  logic [31:1] pc_seq;
  logic [31:1] pc_jump;
  logic [31:0] instr_fetched;

  assign compressed = (fetch_data[1:0] != QuadFull);

  assign pc_seq  = pc + (compressed ? PcStepC : PcStepFull);
  assign pc_jump = pc + jimm[31:1];  // Offset is relative to the jump itself.

  // A compressed instruction leaves the upper half of the window unused.
  assign instr_fetched = compressed ? {16'h0000, fetch_data[15:0]} : fetch_data[31:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc            <= '0;  // Boot address.
      pc_d0         <= '0;
      instr_d0      <= '0;
      compressed_d0 <= 1'b0;
      br_d0         <= 1'b0;
      valid_d0      <= 1'b0;
    end else if (fetch_hold) begin
      valid_d0 <= 1'b0;  // Everything else stays frozen.
    end else begin
      valid_d0 <= 1'b1;
      pc_d0    <= pc;
      if (pc_update) begin
        pc            <= pc_in;
        instr_d0      <= Nop;
        compressed_d0 <= 1'b0;
        br_d0         <= 1'b0;
      end else if (j) begin
        pc            <= pc_jump;
        instr_d0      <= Nop;
        compressed_d0 <= compressed;  // Keeps the jump's size for the link value.
        br_d0         <= 1'b0;
      end else begin
        pc            <= pc_seq;
        instr_d0      <= instr_fetched;
        compressed_d0 <= compressed;
        br_d0         <= br;
      end
    end
  end

  riscv_decoder_br u_dec_br (
    .instr (fetch_data[15:0]),
    .br    (br)
  );

  riscv_decoder_j_no_rr u_dec_j (
    .instr (fetch_data[15:0]),
    .j     (j)
  );

  riscv_decoder_j_no_rr_imm u_dec_j_imm (
    .instr (fetch_data[31:0]),
    .imm   (jimm)
  );

  assign fetch_addr = pc;
  assign pc_out     = pc;

endmodule : if_stage

//--- logic/instr_mem.sv
// Instruction RAM built from even and odd halfword banks.
// Fetch reads 32 bits at any halfword; software loads and reads words over APB.

`timescale 1ns/100ps

module instr_mem
  import instr_defs::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [           31:0] paddr,
  input  logic [           31:0] pwdata,
  input  logic [            3:0] pstrb,
  input  logic [           31:1] fetch_addr,
  output logic [           31:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [MemBusWidth-1:0] fetch_data
);

  logic [15:0] bank_even [ImemBankDepth];
  logic [15:0] bank_odd  [ImemBankDepth];

  logic [ImemBankBits-1:0] fetch_row;
  logic                    fetch_odd;
  logic [ImemBankBits-1:0] even_row;
  logic [15:0]             even_rd;
  logic [15:0]             odd_rd;

  logic                    addr_err;
  logic [ImemBankBits-1:0] apb_row;
  logic                    apb_wr;

  // Fetch path. An odd start takes the next row from the even bank.
  assign fetch_row = fetch_addr[ImemAddrBits:2];
  assign fetch_odd = fetch_addr[1];
  assign even_row  = fetch_row + ImemBankBits'(fetch_odd);  // Wraps at the top.
  assign even_rd   = bank_even[even_row];
  assign odd_rd    = bank_odd[fetch_row];
  assign fetch_data = fetch_odd ? {even_rd, odd_rd} : {odd_rd, even_rd};

  // APB side.
  assign addr_err = (paddr >= 32'(ImemBytes));
  assign apb_row  = paddr[ImemAddrBits:2];
  assign apb_wr   = psel && penable && pwrite && !addr_err;

  assign pready  = 1'b1;  // No wait states.
  assign pslverr = psel && penable && addr_err;

  always_ff @(posedge clk) begin
    if (apb_wr) begin
      if (pstrb[0]) bank_even[apb_row][7:0]  <= pwdata[7:0];
      if (pstrb[1]) bank_even[apb_row][15:8] <= pwdata[15:8];
      if (pstrb[2]) bank_odd[apb_row][7:0]   <= pwdata[23:16];
      if (pstrb[3]) bank_odd[apb_row][15:8]  <= pwdata[31:24];
    end
  end

  // Read data is captured in the setup phase and held through access.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prdata <= '0;
    end else if (psel && !penable && !pwrite) begin
      prdata <= addr_err ? 32'h0 : {bank_odd[apb_row], bank_even[apb_row]};
    end
  end

endmodule : instr_mem

//--- logic/fetch_top.sv
// Fetch front end top: the instruction memory with its APB load port feeding the fetch stage.

`timescale 1ns/100ps

module fetch_top
  import instr_defs::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] paddr,
  input  logic [31:0] pwdata,
  input  logic [ 3:0] pstrb,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  logic        fetch_hold,
  input  logic        pc_update,
  input  logic [31:1] pc_in,
  output logic [31:1] pc_out,
  output logic [31:0] instr_d0,
  output logic [31:1] pc_d0,
  output logic        compressed_d0,
  output logic        br_d0,
  output logic        valid_d0
);

  logic [           31:1] fetch_addr;
  logic [MemBusWidth-1:0] fetch_data;

  instr_mem u_instr_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .fetch_addr (fetch_addr),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .fetch_data (fetch_data)
  );

  if_stage u_if_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_hold    (fetch_hold),
    .pc_update     (pc_update),
    .pc_in         (pc_in),
    .fetch_data    (fetch_data),
    .fetch_addr    (fetch_addr),
    .pc_out        (pc_out),
    .instr_d0      (instr_d0),
    .pc_d0         (pc_d0),
    .compressed_d0 (compressed_d0),
    .br_d0         (br_d0),
    .valid_d0      (valid_d0)
  );

endmodule : fetch_top

//--- sim/clk_gen.sv
// Testbench clock and reset source for the fetch front end.
// Free-running 8 ns clock; rst_n is held low for the first two cycles.

`timescale 1ns/100ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HalfPeriod = 4;

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;  // Released away from the rising edge.
  end

endmodule : clk_gen

//--- sim/fetch_assert.sv
// Concurrent checks on the fetch stage, attached to every if_stage instance by bind.

`timescale 1ns/100ps

module fetch_assert
  import instr_defs::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        fetch_hold,
  input logic        pc_update,
  input logic [31:1] pc_in,
  input logic [31:1] pc_out,
  input logic [31:0] instr_d0,
  input logic        j
);

  a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> (pc_out == '0))
    else $error("pc_out is not zero after reset");

  a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    (pc_update && !fetch_hold) |=> (pc_out == $past(pc_in)))
    else $error("pc_out did not take pc_in after a redirect");

  // Redirects and direct jumps both leave one bubble.
  a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    (!fetch_hold && (pc_update || j)) |=> (instr_d0 == Nop))
    else $error("instr_d0 is not a NOP after a redirect or jump");

  a_hold_pc: assert property (@(posedge clk) disable iff (!rst_n)
    fetch_hold |=> $stable(pc_out))
    else $error("pc_out moved while fetch_hold was high");

endmodule : fetch_assert

bind if_stage fetch_assert u_fetch_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .fetch_hold (fetch_hold),
  .pc_update  (pc_update),
  .pc_in      (pc_in),
  .pc_out     (pc_out),
  .instr_d0   (instr_d0),
  .j          (j)
);

//--- sim/tb_fetch.sv
// Testbench for fetch_top: loads a program over APB, then steps a table of
// hold and redirect controls and compares the d0 outputs with a reference model.

`timescale 1ns/100ps

module tb_fetch;
  import instr_defs::*;

  localparam int WaitLimit  = 16;
  localparam int ResetLimit = 20;
  localparam int NumProg    = 15;
  localparam int NumSteps   = 24;
  localparam int KindPlain  = 0;
  localparam int KindBranch = 1;
  localparam int KindJump   = 2;

  logic        clk, rst_n;
  logic        psel, penable, pwrite;
  logic [31:0] paddr, pwdata, prdata;
  logic [ 3:0] pstrb;
  logic        pready, pslverr;
  logic        fetch_hold, pc_update;
  logic [31:1] pc_in, pc_out, pc_d0;
  logic [31:0] instr_d0;
  logic        compressed_d0, br_d0, valid_d0;

  int          err_count     = 0;
  int          timeout_count = 0;
  logic [31:0] rng_state     = 32'h84c3;

  logic [31:1] prog_addr [NumProg];
  logic [31:0] prog_word [NumProg];
  int          prog_size [NumProg];
  int          prog_kind [NumProg];
  int          prog_off  [NumProg];
  int          prog_count = 0;

  // Per-cycle fetch controls.
  logic        tab_hold [NumSteps] = '{0,0,0,0,1,1,0,0,0,0,0,0,0,0,0,0,0,0,0,0,1,0,0,0};
  logic        tab_upd  [NumSteps] = '{0,0,0,0,0,1,0,0,0,0,0,0,0,0,0,0,0,1,1,0,0,1,0,0};
  logic [31:1] tab_pcin [NumSteps] = '{0,0,0,0,0,19,0,0,0,0,0,0,0,0,0,0,0,10,3,0,0,23,0,0};

  clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  fetch_top uut (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = new_w[8*b +: 8];
    end
    return w;
  endfunction

  function automatic int find_prog(input logic [31:1] hw);
    for (int k = 0; k < prog_count; k++) begin
      if (prog_addr[k] == hw) return k;
    end
    return -1;
  endfunction

  task automatic finish_run();
    $display("Summary: %0d check errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      err_count++;
      $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Inputs change just after the edge.
  endtask

  task automatic apb_transfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output logic err);
    int n;
    psel    = 1'b1;  // Setup phase.
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    pstrb   = strb;
    next_cycle();
    penable = 1'b1;
    n = 0;
    @(posedge clk);
    check_value("pready", pready, 1'b1);  // No wait states in the access phase.
    while (!pready && n < WaitLimit) begin
      n++;
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    if (!pready) begin
      $display("Timeout: APB slave never raised pready at address %h", addr);
      timeout_count++;
    end
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    logic [31:0] unused;
    apb_transfer(1'b1, addr, data, strb, unused, err);
  endtask

  task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
    apb_transfer(1'b0, addr, 32'h0, 4'h0, data, err);
  endtask

  task automatic write_halfword(input logic [31:1] hw, input logic [15:0] val);
    logic        err;
    logic [31:0] addr;
    addr = {hw[31:2], 2'b00};
    if (hw[1]) apb_write(addr, {val, 16'h0}, 4'b1100, err);
    else apb_write(addr, {16'h0, val}, 4'b0011, err);
    check_value("pslverr", err, 0);
  endtask

  task automatic add_prog(input int hw, input logic [31:0] word, input int size,
                          input int kind, input int off);
    prog_addr[prog_count] = hw;
    prog_word[prog_count] = word;
    prog_size[prog_count] = size;
    prog_kind[prog_count] = kind;
    prog_off[prog_count]  = off;  // Byte offset of a jump.
    prog_count++;
  endtask

  task automatic test_apb_access();
    logic [31:0] base, data, rd, merged;
    logic [ 3:0] strb;
    logic        err;

    // Random words merged under random byte strobes.
    for (int k = 0; k < 4; k++) begin
      rng_state = lcg_next(rng_state);
      base = rng_state;
      apb_write(32'h300 + 4 * k, base, 4'hf, err);
      check_value("pslverr", err, 0);
      rng_state = lcg_next(rng_state);
      data = rng_state;
      rng_state = lcg_next(rng_state);
      strb = rng_state[19:16];
      apb_write(32'h300 + 4 * k, data, strb, err);
      merged = merge_bytes(base, data, strb);
      apb_read(32'h300 + 4 * k, rd, err);
      check_value("prdata", rd, merged);
      check_value("pslverr", err, 0);
    end

    // Out of range; this address aliases word 0x30c inside the bank.
    rng_state = lcg_next(rng_state);
    apb_write(ImemBytes + 32'h30c, rng_state, 4'hf, err);
    check_value("pslverr", err, 1);
    apb_read(ImemBytes + 32'h30c, rd, err);
    check_value("prdata", rd, 0);
    check_value("pslverr", err, 1);
    apb_read(32'h30c, rd, err);
    check_value("prdata", rd, merged);
  endtask

  task automatic load_program();
    for (int k = 0; k < prog_count; k++) begin
      write_halfword(prog_addr[k], prog_word[k][15:0]);
      if (prog_size[k] == 2) write_halfword(prog_addr[k] + 31'd1, prog_word[k][31:16]);
    end
  endtask

  task automatic run_fetch_steps();
    logic [31:1] model_pc, next_pc, exp_pc_d0;
    logic [31:0] exp_instr;
    logic        exp_comp, exp_br, exp_valid;
    int          idx;

    model_pc = '0;
    exp_pc_d0 = '0;
    exp_instr = '0;
    exp_comp = 1'b0;
    exp_br = 1'b0;
    for (int i = 0; i < NumSteps; i++) begin
      fetch_hold = tab_hold[i];
      pc_update  = tab_upd[i];
      pc_in      = tab_pcin[i];
      check_value("pc_out", pc_out, model_pc);
      idx = find_prog(model_pc);
      next_pc = model_pc;
      exp_valid = !tab_hold[i];
      if (!tab_hold[i]) begin
        exp_pc_d0 = model_pc;
        exp_br = 1'b0;
        if (tab_upd[i]) begin
          exp_instr = Nop;  // Redirect wins over any jump.
          exp_comp = 1'b0;
          next_pc = tab_pcin[i];
        end else if (idx < 0) begin
          err_count++;
          $display("No program entry at halfword %h", model_pc);
        end else if (prog_kind[idx] == KindJump) begin
          exp_instr = Nop;
          exp_comp = (prog_size[idx] == 1);
          next_pc = model_pc + 31'(prog_off[idx] / 2);
        end else begin
          exp_comp = (prog_size[idx] == 1);
          exp_instr = exp_comp ? {16'h0, prog_word[idx][15:0]} : prog_word[idx];
          exp_br = (prog_kind[idx] == KindBranch);
          next_pc = model_pc + 31'(prog_size[idx]);
        end
      end
      next_cycle();
      check_value("pc_d0", pc_d0, exp_pc_d0);
      check_value("instr_d0", instr_d0, exp_instr);
      check_value("compressed_d0", compressed_d0, exp_comp);
      check_value("br_d0", br_d0, exp_br);
      check_value("valid_d0", valid_d0, exp_valid);
      model_pc = next_pc;
    end
    check_value("pc_out", pc_out, model_pc);
    fetch_hold = 1'b1;
    pc_update = 1'b0;
  endtask

  initial begin
    int n;

    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    pstrb = '0;
    fetch_hold = 1'b1;  // Fetch stays frozen while code is loaded.
    pc_update = 1'b0;
    pc_in = '0;

    add_prog(0, 32'h0050_0093, 2, KindPlain, 0);    // addi x1,x0,5
    add_prog(2, 32'h0000_450d, 1, KindPlain, 0);    // c.li a0,3
    add_prog(3, 32'h0020_81b3, 2, KindPlain, 0);    // add at an odd halfword
    add_prog(5, 32'h0000_85aa, 1, KindPlain, 0);    // c.mv
    add_prog(6, 32'h0020_8463, 2, KindBranch, 0);   // beq x1,x2,8
    add_prog(8, 32'h0000_c011, 1, KindBranch, 0);   // c.beqz
    add_prog(9, 32'h0000_fcf5, 1, KindBranch, 0);   // c.bnez
    add_prog(10, 32'h0100_00ef, 2, KindJump, 16);   // jal x1,+16
    add_prog(18, 32'h0000_a019, 1, KindJump, 6);    // c.j +6
    add_prog(19, 32'h0000_a001, 1, KindJump, 0);    // c.j 0, parks fetch
    add_prog(21, 32'h1234_52b7, 2, KindPlain, 0);   // lui at an odd halfword
    add_prog(23, 32'h0000_2021, 1, KindJump, 8);    // c.jal +8
    add_prog(24, 32'h0000_bfdd, 1, KindJump, -10);  // c.j -10
    add_prog(27, 32'h0000_0001, 1, KindPlain, 0);   // c.nop
    add_prog(28, 32'hff9f_f06f, 2, KindJump, -8);   // jal x0,-8

    n = 0;
    @(posedge clk);
    while (!rst_n && n < ResetLimit) begin
      n++;
      @(posedge clk);
    end
    if (!rst_n) begin
      $display("Timeout: reset was never released");
      timeout_count++;
    end else begin
      #1;
      test_apb_access();
      load_program();
      run_fetch_steps();
    end

    finish_run();
  end

endmodule : tb_fetch

//--- flist.f
common/instr_defs.sv
fetch/riscv_decoder_br.sv
fetch/riscv_decoder_j_no_rr.sv
fetch/riscv_decoder_j_no_rr_imm.sv
fetch/if_stage.sv
logic/instr_mem.sv
logic/fetch_top.sv
sim/clk_gen.sv
sim/fetch_assert.sv
sim/tb_fetch.sv
